// File: include/addr_map_params.svh
`ifndef ADDR_MAP_PARAMS_SVH
`define ADDR_MAP_PARAMS_SVH

// ----------------------------------------------------------------------
// input side
// ----------------------------------------------------------------------

// lanes in one FIFO word
`define AM_LANES 16

// bits per lane
`define AM_LANE_W 32

// reads gathered into one block
`define AM_READS_PER_BLOCK 4

// ----------------------------------------------------------------------
// block coordinates within a layer
// ----------------------------------------------------------------------

// rows per batch, innermost
`define AM_ROWS 16

// columns per row
`define AM_COLS 64

// batches per layer, outermost
`define AM_BATCHES 2

// ----------------------------------------------------------------------
// output side and layer table
// ----------------------------------------------------------------------

// write address width
`define AM_ADDR_W 28

// entries in the layer-type table
`define AM_LAYERS 64

// layer counter width
`define AM_LAYER_W 7

`endif

// File: source/addr_map_pkg.sv
`include "addr_map_params.svh"

package addr_map_pkg;

    // ------------------------------------------------------------------
    // layer kinds of the network
    // ------------------------------------------------------------------
    // only conv has a datapath in this mapper
    typedef enum logic [2:0] {
        LT_CONV    = 3'd0,
        LT_DW      = 3'd1,
        LT_PW      = 3'd2,
        LT_AVGPL   = 3'd3,
        LT_PW_SC   = 3'd4
    } layer_type_e;

    // ------------------------------------------------------------------
    // data and address words
    // ------------------------------------------------------------------

    // four reads of one lane, first read on top
    typedef logic [`AM_READS_PER_BLOCK*`AM_LANE_W-1:0] lane_word_t;

    typedef logic [`AM_ADDR_W-1:0] wr_addr_t;

    // picture edge length, 0 past the last sized layer
    typedef logic [7:0] pic_size_t;

    // ------------------------------------------------------------------
    // block position inside a layer
    // ------------------------------------------------------------------
    typedef struct packed {
        logic [$clog2(`AM_ROWS)-1:0]    row;
        logic [$clog2(`AM_COLS)-1:0]    col;
        logic [$clog2(`AM_BATCHES)-1:0] batch;
    } block_coord_t;

endpackage

// File: source/block_if.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

interface block_if;

    // one-cycle strobe, block gathered
    logic                     blk_vld;
    // lane registers, held while the writer drains
    addr_map_pkg::lane_word_t blk_lanes [`AM_LANES];
    // coordinates of the gathered block
    addr_map_pkg::block_coord_t blk_coord;
    // writer still owns the lanes
    logic                     blk_busy;

    modport gather (
        output blk_vld,
        output blk_lanes,
        output blk_coord,
        input  blk_busy
    );

    modport writer (
        input  blk_vld,
        input  blk_lanes,
        input  blk_coord,
        output blk_busy
    );

endinterface

// File: source/layer_sequencer.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

module layer_sequencer (
    input  logic                        clk_200M,
    input  logic                        rst_n,
    input  logic                        layer_done_i,
    output logic                        conv_active_o,
    output addr_map_pkg::pic_size_t     pic_size_o,
    output logic [`AM_LAYER_W-1:0]      layer_num_o
);

    logic [`AM_LAYER_W-1:0]   layer_q;
    addr_map_pkg::layer_type_e cur_type;

    // ------------------------------------------------------------------
    // layer counter
    // ------------------------------------------------------------------
    // holds at the last table entry
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            layer_q <= '0;
        end else if (layer_done_i && int'(layer_q) < `AM_LAYERS - 1) begin
            layer_q <= layer_q + 1'b1;
        end
    end

    assign layer_num_o = layer_q;

    // ------------------------------------------------------------------
    // layer-type table
    // ------------------------------------------------------------------
    // only non-pointwise entries listed, holes fall to pointwise
    always_comb begin
        case (int'(layer_q))
            0: begin
                cur_type = addr_map_pkg::LT_CONV;
            end
            1, 4, 7, 11, 14, 18, 22, 25, 29,
            33, 37, 40, 44, 48, 51, 55, 59: begin
                cur_type = addr_map_pkg::LT_DW;
            end
            8, 15, 19, 26, 30, 34, 41, 45, 52, 56: begin
                cur_type = addr_map_pkg::LT_PW_SC;
            end
            62: begin
                cur_type = addr_map_pkg::LT_AVGPL;
            end
            default: begin
                cur_type = addr_map_pkg::LT_PW;
            end
        endcase
    end

    assign conv_active_o = (cur_type == addr_map_pkg::LT_CONV);

    // ------------------------------------------------------------------
    // picture size per layer
    // ------------------------------------------------------------------
    // size halves at each downsampling layer
    always_comb begin
        if (int'(layer_q) <= 0) begin
            pic_size_o = 8'd128;
        end else if (int'(layer_q) <= 4) begin
            pic_size_o = 8'd64;
        end else if (int'(layer_q) <= 11) begin
            pic_size_o = 8'd32;
        end else if (int'(layer_q) <= 22) begin
            pic_size_o = 8'd16;
        end else if (int'(layer_q) <= 48) begin
            pic_size_o = 8'd8;
        end else if (int'(layer_q) <= 62) begin
            pic_size_o = 8'd4;
        end else begin
            pic_size_o = 8'd0;
        end
    end

endmodule

// File: source/read_gather.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

module read_gather (
    input  logic                              clk_200M,
    input  logic                              rst_n,
    input  logic [`AM_LANES*`AM_LANE_W-1:0]   fifo_rd_data_i,
    input  logic                              fifo_empty_i,
    output logic                              fifo_rd_req_o,
    input  logic                              conv_active_i,
    output logic                              layer_done_o,
    block_if.gather                           blk
);

    localparam int RD_CNT_W = $clog2(`AM_READS_PER_BLOCK);
    localparam int ROW_W    = $clog2(`AM_ROWS);
    localparam int COL_W    = $clog2(`AM_COLS);
    localparam int BAT_W    = $clog2(`AM_BATCHES);
    localparam int KEEP_W   = (`AM_READS_PER_BLOCK - 1) * `AM_LANE_W;

    logic [RD_CNT_W-1:0]        rd_cnt_q;
    addr_map_pkg::block_coord_t pos_q;
    logic                       rd_hs;
    logic                       last_rd;
    logic                       row_wrap;
    logic                       col_wrap;
    logic                       bat_wrap;

    assign rd_hs    = fifo_rd_req_o && !fifo_empty_i;
    assign last_rd  = rd_hs && (rd_cnt_q == RD_CNT_W'(`AM_READS_PER_BLOCK - 1));
    assign row_wrap = (pos_q.row == ROW_W'(`AM_ROWS - 1));
    assign col_wrap = (pos_q.col == COL_W'(`AM_COLS - 1));
    assign bat_wrap = (pos_q.batch == BAT_W'(`AM_BATCHES - 1));

    // fourth read of the last block of the layer
    assign layer_done_o = last_rd && row_wrap && col_wrap && bat_wrap;

    // ------------------------------------------------------------------
    // read request
    // ------------------------------------------------------------------
    // drops after the fourth handshake, stays low while the writer
    // holds the lanes
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            fifo_rd_req_o <= 1'b0;
        end else begin
            fifo_rd_req_o <= !fifo_empty_i && conv_active_i && !blk.blk_busy && !last_rd;
        end
    end

    // ------------------------------------------------------------------
    // handshake and block coordinate counters
    // ------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            rd_cnt_q    <= '0;
            pos_q       <= '0;
            blk.blk_vld <= 1'b0;
        end else begin
            blk.blk_vld <= last_rd;
            if (last_rd) begin
                rd_cnt_q <= '0;
            end else if (rd_hs) begin
                rd_cnt_q <= rd_cnt_q + 1'b1;
            end
            // row innermost, then column, then batch
            if (last_rd) begin
                if (!row_wrap) begin
                    pos_q.row <= pos_q.row + 1'b1;
                end else begin
                    pos_q.row <= '0;
                    if (!col_wrap) begin
                        pos_q.col <= pos_q.col + 1'b1;
                    end else begin
                        pos_q.col   <= '0;
                        pos_q.batch <= bat_wrap ? '0 : pos_q.batch + 1'b1;
                    end
                end
            end
        end
    end

    // ------------------------------------------------------------------
    // lane reorder registers
    // ------------------------------------------------------------------
    // coordinates captured before the counters step
    always_ff @(posedge clk_200M) begin
        if (last_rd) begin
            blk.blk_coord <= pos_q;
        end
        if (rd_hs) begin
            for (int i = 0; i < `AM_LANES; i++) begin
                // oldest read ends up in the top word
                blk.blk_lanes[i] <= {blk.blk_lanes[i][KEEP_W-1:0],
                                     fifo_rd_data_i[i*`AM_LANE_W +: `AM_LANE_W]};
            end
        end
    end

endmodule

// File: source/block_writer.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

module block_writer (
    input  logic                        clk_200M,
    input  logic                        rst_n,
    input  addr_map_pkg::pic_size_t     pic_size_i,
    block_if.writer                     blk,
    output logic                        fifo_wr_req_o,
    output addr_map_pkg::wr_addr_t      fifo_wr_addr_o,
    output addr_map_pkg::lane_word_t    fifo_wr_data_o
);

    localparam int LANE_IDX_W = $clog2(`AM_LANES);

    logic                       drain_q;
    logic [LANE_IDX_W-1:0]      lane_q;
    addr_map_pkg::block_coord_t coord_q;
    addr_map_pkg::pic_size_t    pic_q;
    logic                       issue;
    logic [LANE_IDX_W-1:0]      lane_idx;
    addr_map_pkg::block_coord_t coord_cur;
    addr_map_pkg::wr_addr_t     p_ext;
    addr_map_pkg::wr_addr_t     pp;
    addr_map_pkg::wr_addr_t     addr_next;

    // lane 0 goes out straight from the strobe, lanes 1..15 from the drain
    assign issue     = blk.blk_vld || drain_q;
    assign lane_idx  = blk.blk_vld ? '0 : lane_q;
    assign coord_cur = blk.blk_vld ? blk.blk_coord : coord_q;
    assign blk.blk_busy = blk.blk_vld || fifo_wr_req_o;

    // ------------------------------------------------------------------
    // write address
    // ------------------------------------------------------------------
    // k*P*P/4 + row*P + col + batch*4*P*P
    assign p_ext     = addr_map_pkg::wr_addr_t'(pic_q);
    assign pp        = p_ext * p_ext;
    assign addr_next = addr_map_pkg::wr_addr_t'(lane_idx) * (pp >> 2)
                     + addr_map_pkg::wr_addr_t'(coord_cur.row) * p_ext
                     + addr_map_pkg::wr_addr_t'(coord_cur.col)
                     + addr_map_pkg::wr_addr_t'(coord_cur.batch) * (pp << 2);

    // ------------------------------------------------------------------
    // lane counter
    // ------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            drain_q <= 1'b0;
            lane_q  <= '0;
        end else if (blk.blk_vld) begin
            drain_q <= 1'b1;
            lane_q  <= LANE_IDX_W'(1);
        end else if (drain_q) begin
            lane_q <= lane_q + 1'b1;
            if (lane_q == LANE_IDX_W'(`AM_LANES - 1)) begin
                drain_q <= 1'b0;
            end
        end
    end

    // picture size sampled while idle, so a layer step at the last
    // block does not reach its addresses
    always_ff @(posedge clk_200M) begin
        if (!blk.blk_busy) begin
            pic_q <= pic_size_i;
        end
        if (blk.blk_vld) begin
            coord_q <= blk.blk_coord;
        end
    end

    // ------------------------------------------------------------------
    // write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk_200M or negedge rst_n) begin
        if (!rst_n) begin
            fifo_wr_req_o  <= 1'b0;
            fifo_wr_addr_o <= '0;
            fifo_wr_data_o <= '0;
        end else begin
            fifo_wr_req_o  <= issue;
            fifo_wr_addr_o <= issue ? addr_next : '0;
            fifo_wr_data_o <= issue ? blk.blk_lanes[lane_idx] : '0;
        end
    end

endmodule

// File: source/addr_map.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

module addr_map (
    input  logic                              clk_200M,
    input  logic                              rst_n,

    // input FIFO, request/empty handshake
    input  logic [`AM_LANES*`AM_LANE_W-1:0]   fifo_rd_data_i,
    input  logic                              fifo_empty_i,
    output logic                              fifo_rd_req_o,

    // write FIFO, never full
    output logic                              fifo_wr_req_o,
    output addr_map_pkg::wr_addr_t            fifo_wr_addr_o,
    output addr_map_pkg::lane_word_t          fifo_wr_data_o,

    output logic [`AM_LAYER_W-1:0]            layer_num_o
);

    logic                       conv_active;
    logic                       layer_done;
    addr_map_pkg::pic_size_t    pic_size;

    block_if blk_bus ();

    // ------------------------------------------------------------------
    // layer control
    // ------------------------------------------------------------------
    layer_sequencer u_layer_sequencer (
        .clk_200M      (clk_200M),
        .rst_n         (rst_n),
        .layer_done_i  (layer_done),
        .conv_active_o (conv_active),
        .pic_size_o    (pic_size),
        .layer_num_o   (layer_num_o)
    );

    // ------------------------------------------------------------------
    // gather, then drain
    // ------------------------------------------------------------------
    read_gather u_read_gather (
        .clk_200M       (clk_200M),
        .rst_n          (rst_n),
        .fifo_rd_data_i (fifo_rd_data_i),
        .fifo_empty_i   (fifo_empty_i),
        .fifo_rd_req_o  (fifo_rd_req_o),
        .conv_active_i  (conv_active),
        .layer_done_o   (layer_done),
        .blk            (blk_bus)
    );

    block_writer u_block_writer (
        .clk_200M       (clk_200M),
        .rst_n          (rst_n),
        .pic_size_i     (pic_size),
        .blk            (blk_bus),
        .fifo_wr_req_o  (fifo_wr_req_o),
        .fifo_wr_addr_o (fifo_wr_addr_o),
        .fifo_wr_data_o (fifo_wr_data_o)
    );

endmodule

// File: verif/tb_addr_map.sv
`timescale 1ns/1ns
`include "addr_map_params.svh"

module tb_addr_map;

    localparam int TIMEOUT    = 200;
    localparam int PIC0       = 128;
    localparam int LAYER_BLKS = `AM_ROWS * `AM_COLS * `AM_BATCHES;

    typedef logic [`AM_LANES*`AM_LANE_W-1:0] fifo_word_t;
    typedef logic [`AM_LAYER_W-1:0]          layer_num_t;

    logic                     clk_200M = 1'b0;
    logic                     rst_n = 1'b0;
    fifo_word_t               fifo_rd_data_i = '0;
    logic                     fifo_empty_i = 1'b1;
    logic                     fifo_rd_req_o;
    logic                     fifo_wr_req_o;
    addr_map_pkg::wr_addr_t   fifo_wr_addr_o;
    addr_map_pkg::lane_word_t fifo_wr_data_o;
    layer_num_t               layer_num_o;

    // input FIFO model, a ring of 16 words
    fifo_word_t               in_buf [16];
    logic [3:0]               push_ptr = '0;
    logic [3:0]               pop_ptr = '0;
    // first word of the next block, queued early so an extra read shows up
    fifo_word_t               ahead_word;
    bit                       ahead_valid = 1'b0;
    // writes seen on the output port
    addr_map_pkg::wr_addr_t   cap_addr [64];
    addr_map_pkg::lane_word_t cap_data [64];
    logic [5:0]               cap_wr_ptr = '0;
    logic [5:0]               cap_rd_ptr = '0;
    int                       cap_cnt = 0;
    int                       hs_cnt = 0;
    int                       wr_run = 0;
    int                       mon_errors = 0;
    int                       errors = 0;
    bit                       timed_out = 1'b0;
    logic [31:0]              lcg_state = 32'd30024;
    addr_map_pkg::wr_addr_t   first_addr;

    always #20 clk_200M = ~clk_200M;

    addr_map UUT (
        .clk_200M       (clk_200M),
        .rst_n          (rst_n),
        .fifo_rd_data_i (fifo_rd_data_i),
        .fifo_empty_i   (fifo_empty_i),
        .fifo_rd_req_o  (fifo_rd_req_o),
        .fifo_wr_req_o  (fifo_wr_req_o),
        .fifo_wr_addr_o (fifo_wr_addr_o),
        .fifo_wr_data_o (fifo_wr_data_o),
        .layer_num_o    (layer_num_o)
    );

    // ------------------------------------------------------------------
    // FIFO model and write monitor
    // ------------------------------------------------------------------
    always @(posedge clk_200M) begin
        if (fifo_rd_req_o && !fifo_empty_i) begin
            pop_ptr = pop_ptr + 1'b1;
            hs_cnt  = hs_cnt + 1;
        end
        if (fifo_rd_req_o && fifo_wr_req_o) begin
            mon_errors++;
            $display("Error: read request high during a write cycle");
        end
        if (fifo_wr_req_o) begin
            cap_addr[cap_wr_ptr] = fifo_wr_addr_o;
            cap_data[cap_wr_ptr] = fifo_wr_data_o;
            cap_wr_ptr = cap_wr_ptr + 1'b1;
            cap_cnt++;
            wr_run++;
        end else if (wr_run != 0) begin
            if (wr_run != `AM_LANES) begin
                mon_errors++;
                $display("Error: write burst lasted %0d cycles instead of 16", wr_run);
            end
            wr_run = 0;
        end
        // show-ahead: head word is on the bus while not empty
        fifo_empty_i   <= (pop_ptr == push_ptr);
        fifo_rd_data_i <= (pop_ptr == push_ptr) ? '0 : in_buf[pop_ptr];
    end

    // ------------------------------------------------------------------
    // stimulus helpers and model
    // ------------------------------------------------------------------
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fifo_word_t random_word();
        fifo_word_t w;
        for (int i = 0; i < `AM_LANES; i++) begin
            w[i*`AM_LANE_W +: `AM_LANE_W] = lcg_next();
        end
        return w;
    endfunction

    // block index to row, column and batch, row innermost
    function automatic addr_map_pkg::wr_addr_t expected_addr(input int b, input int k);
        int row;
        int col;
        int batch;
        int a;
        row   = b % `AM_ROWS;
        col   = (b / `AM_ROWS) % `AM_COLS;
        batch = b / (`AM_ROWS * `AM_COLS);
        a = k * PIC0 * PIC0 / 4 + row * PIC0 + col + batch * 4 * PIC0 * PIC0;
        return a[`AM_ADDR_W-1:0];
    endfunction

    task automatic push_word(input fifo_word_t w);
        in_buf[push_ptr] = w;
        push_ptr = push_ptr + 1'b1;
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic compare_lane(input string name, input addr_map_pkg::lane_word_t got,
                                input addr_map_pkg::lane_word_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%032h expected 0x%032h", name, got, exp);
        end
    endtask

    task automatic compare_addr(input string name, input addr_map_pkg::wr_addr_t got,
                                input addr_map_pkg::wr_addr_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%07h expected 0x%07h", name, got, exp);
        end
    endtask

    task automatic compare_layer(input string name, input layer_num_t got, input layer_num_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got 0x%02h expected 0x%02h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------
    // bounded waits
    // ------------------------------------------------------------------
    task automatic wait_reads(input int target);
        int cyc;
        cyc = 0;
        while (hs_cnt < target && cyc < TIMEOUT) begin
            @(negedge clk_200M);
            cyc++;
        end
        if (hs_cnt < target) begin
            timed_out = 1'b1;
            errors++;
            $display("Error: timed out waiting for FIFO reads");
        end
    endtask

    task automatic wait_writes(input int target);
        int cyc;
        cyc = 0;
        while (cap_cnt < target && cyc < TIMEOUT) begin
            @(negedge clk_200M);
            cyc++;
        end
        if (cap_cnt < target) begin
            timed_out = 1'b1;
            errors++;
            $display("Error: timed out waiting for block writes");
        end
    endtask

    task automatic wait_layer(input layer_num_t target);
        int cyc;
        cyc = 0;
        while (layer_num_o !== target && cyc < TIMEOUT && !timed_out) begin
            @(negedge clk_200M);
            cyc++;
        end
        if (layer_num_o !== target) begin
            timed_out = 1'b1;
            errors++;
            $display("Error: timed out waiting for the layer number to advance");
        end
    endtask

    // ------------------------------------------------------------------
    // one block: four reads in, sixteen writes out
    // ------------------------------------------------------------------
    task automatic run_block(input int b, input bit split,
                             output addr_map_pkg::wr_addr_t lane0_addr);
        fifo_word_t               words [4];
        addr_map_pkg::lane_word_t exp_lane;
        int                       hs_start;
        int                       cap_start;
        lane0_addr = '0;
        if (timed_out) begin
            return;
        end
        hs_start  = hs_cnt;
        cap_start = cap_cnt;
        words[0] = ahead_valid ? ahead_word : random_word();
        for (int i = 1; i < `AM_READS_PER_BLOCK; i++) begin
            words[i] = random_word();
        end
        if (!ahead_valid) begin
            push_word(words[0]);
        end
        push_word(words[1]);
        if (split) begin
            // FIFO runs dry after two reads
            wait_reads(hs_start + 2);
            if (timed_out) begin
                return;
            end
            repeat (6) @(negedge clk_200M);
            if (hs_cnt != hs_start + 2 || cap_cnt != cap_start) begin
                errors++;
                $display("Error: block %0d moved on while the FIFO was empty", b);
            end
        end
        push_word(words[2]);
        push_word(words[3]);
        // next block's first word is already waiting, a fifth read would take it
        ahead_word  = random_word();
        ahead_valid = 1'b1;
        push_word(ahead_word);
        wait_writes(cap_start + `AM_LANES);
        if (timed_out) begin
            return;
        end
        lane0_addr = cap_addr[cap_rd_ptr];
        for (int k = 0; k < `AM_LANES; k++) begin
            exp_lane = {words[0][k*`AM_LANE_W +: `AM_LANE_W], words[1][k*`AM_LANE_W +: `AM_LANE_W],
                        words[2][k*`AM_LANE_W +: `AM_LANE_W], words[3][k*`AM_LANE_W +: `AM_LANE_W]};
            compare_addr($sformatf("fifo_wr_addr_o block %0d lane %0d", b, k),
                         cap_addr[cap_rd_ptr], expected_addr(b, k));
            compare_lane($sformatf("fifo_wr_data_o block %0d lane %0d", b, k),
                         cap_data[cap_rd_ptr], exp_lane);
            cap_rd_ptr = cap_rd_ptr + 1'b1;
        end
        if (hs_cnt - hs_start != `AM_READS_PER_BLOCK) begin
            errors++;
            $display("Error: block %0d took %0d reads instead of 4", b, hs_cnt - hs_start);
        end
    endtask

    // ------------------------------------------------------------------
    // directed tests
    // ------------------------------------------------------------------
    task automatic test_reset_idle();
        for (int c = 0; c < 12; c++) begin
            @(negedge clk_200M);
            compare_bit("fifo_rd_req_o", fifo_rd_req_o, 1'b0);
            compare_bit("fifo_wr_req_o", fifo_wr_req_o, 1'b0);
        end
        compare_layer("layer_num_o", layer_num_o, layer_num_t'(0));
    endtask

    task automatic test_empty_stall();
        run_block(1, 1'b1, first_addr);
        compare_addr("block 1 row term", first_addr, addr_map_pkg::wr_addr_t'(PIC0));
    endtask

    task automatic test_coordinates();
        for (int b = 2; b <= `AM_ROWS * `AM_COLS; b++) begin
            run_block(b, 1'b0, first_addr);
            if (b == 16) begin
                compare_addr("block 16 column term", first_addr, addr_map_pkg::wr_addr_t'(1));
            end else if (b == 64) begin
                compare_addr("block 64 column term", first_addr, addr_map_pkg::wr_addr_t'(4));
            end else if (b == `AM_ROWS * `AM_COLS) begin
                compare_addr("block 1024 batch term", first_addr,
                             addr_map_pkg::wr_addr_t'(4 * PIC0 * PIC0));
            end
        end
        compare_layer("layer_num_o", layer_num_o, layer_num_t'(0));
    endtask

    task automatic test_layer_end();
        int  hs_start;
        bit  seen_req;
        for (int b = `AM_ROWS * `AM_COLS + 1; b < LAYER_BLKS; b++) begin
            run_block(b, 1'b0, first_addr);
        end
        wait_layer(layer_num_t'(1));
        compare_layer("layer_num_o", layer_num_o, layer_num_t'(1));
        hs_start = hs_cnt;
        seen_req = 1'b0;
        for (int i = 0; i < `AM_READS_PER_BLOCK; i++) begin
            push_word(random_word());
        end
        // next layer is depthwise, nothing may be read
        for (int c = 0; c < 100; c++) begin
            @(negedge clk_200M);
            seen_req = seen_req | fifo_rd_req_o;
        end
        if (seen_req || hs_cnt != hs_start) begin
            errors++;
            $display("Error: read request issued after layer 0 finished");
        end
    endtask

    initial begin
        repeat (8) @(posedge clk_200M);
        rst_n <= 1'b1;
        @(negedge clk_200M);
        test_reset_idle();
        run_block(0, 1'b0, first_addr);
        test_empty_stall();
        test_coordinates();
        test_layer_end();
        $display("Error count: %0d check errors, %0d monitor errors", errors, mon_errors);
        if (errors == 0 && mon_errors == 0 && !timed_out) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+include
source/addr_map_pkg.sv
source/block_if.sv
source/layer_sequencer.sv
source/read_gather.sv
source/block_writer.sv
source/addr_map.sv
verif/tb_addr_map.sv

// File: run_sim.sh
#!/bin/sh
# build and run the addr_map testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module tb_addr_map \
    -f project.f \
    -o tb_addr_map_sim

./obj_dir/tb_addr_map_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

echo "simulation finished without failures"
